//--- logic/ddr_rx_pkg.sv
// shared definitions for the HDR-DDR receive path
// receive mode codes, CRC word token, CRC-5 seed and polynomial, field widths

package ddr_rx_pkg;

  // field widths in bits
  parameter int BYTE_W  = 8;
  parameter int CRC_W   = 5;
  parameter int TOKEN_W = 4;
  parameter int PAR_W   = 2;

  // receive modes issued by the sequencer
  typedef enum logic [3:0] {
    PREAMBLE           = 4'b0000,
    CRC_PREAMBLE       = 4'b0001,
    DESERIALIZING_BYTE = 4'b0011,
    CHECK_TOKEN        = 4'b0101,
    CHECK_PAR_VALUE    = 4'b0110,
    CHECK_CRC_VALUE    = 4'b0111,
    IDLE_MODE          = 4'b1000
  } rx_mode_e;

  // token that opens the CRC word
  parameter logic [TOKEN_W-1:0] CRC_TOKEN = 4'hC;

  // CRC-5 start value
  parameter logic [CRC_W-1:0] CRC_SEED = 5'h1f;

  // x^5 + x^2 + 1 with the x^5 term implied
  parameter logic [CRC_W-1:0] CRC_POLY = 5'h05;

endpackage

//--- logic/scl_gen.sv
// SCL generator with one-cycle edge strobes

module scl_gen #(
  parameter int SCL_HALF_CYCLES = 4
) (
  input  logic i_sys_clk,
  input  logic i_sys_rst,
  input  logic i_run,
  output logic o_scl,
  output logic o_scl_pos_edge,
  output logic o_scl_neg_edge
);

  localparam int CNT_W = $clog2(SCL_HALF_CYCLES + 1);

  logic [CNT_W-1:0] half_cnt;
  logic             active;
  logic             half_end;

  // keep running while SCL is high so it always rests low
  assign active   = i_run || o_scl;
  assign half_end = (half_cnt == CNT_W'(SCL_HALF_CYCLES - 1));

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      half_cnt       <= '0;
      o_scl          <= 1'b0;
      o_scl_pos_edge <= 1'b0;
      o_scl_neg_edge <= 1'b0;
    end
    else
    begin
      o_scl_pos_edge <= 1'b0;
      o_scl_neg_edge <= 1'b0;
      if (!active)
      begin
        half_cnt <= '0;
      end
      else if (half_end)
      begin
        half_cnt       <= '0;
        o_scl          <= !o_scl;
        // strobe lands in the same cycle as the new level
        o_scl_pos_edge <= !o_scl;
        o_scl_neg_edge <= o_scl;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

endmodule

//--- logic/crc5_engine.sv
// CRC-5 calculator fed one byte per strobe, MSB first

module crc5_engine (
  input  logic                          i_sys_clk,
  input  logic                          i_sys_rst,
  input  logic                          i_clear,
  input  logic                          i_byte_valid,
  input  logic [ddr_rx_pkg::BYTE_W-1:0] i_byte,
  output logic [ddr_rx_pkg::CRC_W-1:0]  o_crc
);

  import ddr_rx_pkg::*;

  // eight serial steps unrolled into one clock
  function automatic logic [CRC_W-1:0] crc_next(
    input logic [CRC_W-1:0]  crc_in,
    input logic [BYTE_W-1:0] data
  );
    logic [CRC_W-1:0] crc;
    logic             fb;
    crc = crc_in;
    for (int i = BYTE_W - 1; i >= 0; i--)
    begin
      fb  = crc[CRC_W-1] ^ data[i];
      crc = {crc[CRC_W-2:0], 1'b0};
      if (fb)
      begin
        crc = crc ^ CRC_POLY;
      end
    end
    return crc;
  endfunction

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      o_crc <= CRC_SEED;
    end
    else if (i_clear)
    begin
      // new message
      o_crc <= CRC_SEED;
    end
    else if (i_byte_valid)
    begin
      o_crc <= crc_next(o_crc, i_byte);
    end
  end

endmodule

//--- logic/ddr_rx.sv
// HDR-DDR bit deserializer driven by the receive mode
// preamble capture, byte assembly, parity, token and CRC comparison

module ddr_rx (
  input  logic                          i_sys_clk,
  input  logic                          i_sys_rst,
  input  logic                          i_rx_en,
  input  ddr_rx_pkg::rx_mode_e          i_rx_mode,
  input  logic                          i_scl_pos_edge,
  input  logic                          i_scl_neg_edge,
  input  logic                          i_sda,
  input  logic [ddr_rx_pkg::CRC_W-1:0]  i_crc_value,
  output logic [ddr_rx_pkg::BYTE_W-1:0] o_rx_data,
  output logic                          o_crc_byte_valid,
  output logic                          o_mode_done,
  output logic                          o_pre_bit,
  output logic                          o_error
);

  import ddr_rx_pkg::*;

  logic                  sample;
  logic                  finish;
  logic                  last_bit;
  logic [2:0]            bit_cnt;
  logic [2:0]            last_idx;
  logic                  done_pend;
  logic                  byte_sel;
  logic [BYTE_W-1:0]     data_sr;
  logic [CRC_W-1:0]      chk_sr;
  logic [2*BYTE_W-1:0]   par_word;
  logic [PAR_W-1:0]      par_calc;
  logic                  chk_fail;

  // one bit per SCL edge, taken while the strobe is up
  assign sample   = i_rx_en && (i_scl_pos_edge || i_scl_neg_edge) &&
                    (i_rx_mode != IDLE_MODE);
  // mode wraps up one clock after its last bit
  assign finish   = i_rx_en && done_pend;
  assign last_bit = (bit_cnt == last_idx);

  // index of the last bit in each mode
  always_comb
  begin
    case (i_rx_mode)
      DESERIALIZING_BYTE: last_idx = 3'(BYTE_W - 1);
      CHECK_TOKEN:        last_idx = 3'(TOKEN_W - 1);
      CHECK_PAR_VALUE:    last_idx = 3'(PAR_W - 1);
      CHECK_CRC_VALUE:    last_idx = 3'(CRC_W - 1);
      // both preamble modes take a single bit
      default:            last_idx = 3'd0;
    endcase
  end

  // P1 over odd bits, P0 over even bits inverted
  assign par_calc[1] = ^(par_word & 16'haaaa);
  assign par_calc[0] = ~(^(par_word & 16'h5555));

  // compare the low bits of the check register per mode
  always_comb
  begin
    case (i_rx_mode)
      // second preamble bit of a CRC word must be 1
      CRC_PREAMBLE:    chk_fail = !chk_sr[0];
      CHECK_TOKEN:     chk_fail = (chk_sr[TOKEN_W-1:0] != CRC_TOKEN);
      CHECK_PAR_VALUE: chk_fail = (chk_sr[PAR_W-1:0] != par_calc);
      CHECK_CRC_VALUE: chk_fail = (chk_sr != i_crc_value);
      default:         chk_fail = 1'b0;
    endcase
  end

  // bit counting and strobes
  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      bit_cnt          <= '0;
      done_pend        <= 1'b0;
      byte_sel         <= 1'b0;
      o_mode_done      <= 1'b0;
      o_crc_byte_valid <= 1'b0;
      o_pre_bit        <= 1'b0;
      o_error          <= 1'b0;
    end
    else
    begin
      o_mode_done      <= 1'b0;
      o_crc_byte_valid <= 1'b0;
      o_error          <= 1'b0;
      if (!i_rx_en)
      begin
        bit_cnt   <= '0;
        done_pend <= 1'b0;
        byte_sel  <= 1'b0;
      end
      else if (done_pend)
      begin
        done_pend   <= 1'b0;
        bit_cnt     <= '0;
        o_mode_done <= 1'b1;
        o_error     <= chk_fail;
        if (i_rx_mode == DESERIALIZING_BYTE)
        begin
          // byte goes to host and CRC engine together
          o_crc_byte_valid <= 1'b1;
          byte_sel         <= !byte_sel;
        end
      end
      else if (sample)
      begin
        if (i_rx_mode == PREAMBLE)
        begin
          // new word so restart at the high byte
          o_pre_bit <= i_sda;
          byte_sel  <= 1'b0;
        end
        if (last_bit)
        begin
          done_pend <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // shift registers and the word kept for parity
  always_ff @(posedge i_sys_clk)
  begin
    if (sample)
    begin
      if (i_rx_mode == DESERIALIZING_BYTE)
      begin
        data_sr <= {data_sr[BYTE_W-2:0], i_sda};
      end
      else
      begin
        // token, parity and CRC all land here MSB first
        chk_sr <= {chk_sr[CRC_W-2:0], i_sda};
      end
    end
    if (finish && (i_rx_mode == DESERIALIZING_BYTE))
    begin
      o_rx_data <= data_sr;
      if (byte_sel)
      begin
        par_word[BYTE_W-1:0] <= data_sr;
      end
      else
      begin
        par_word[2*BYTE_W-1:BYTE_W] <= data_sr;
      end
    end
  end

endmodule

//--- logic/ddr_rx_ctrl.sv
// message sequencer for the receive path
// walks the mode order per word, counts data words, ends the message

module ddr_rx_ctrl #(
  parameter int MAX_WORDS = 8
) (
  input  logic                 i_sys_clk,
  input  logic                 i_sys_rst,
  input  logic                 i_rx_start,
  input  logic                 i_mode_done,
  input  logic                 i_pre_bit,
  input  logic                 i_error,
  output logic                 o_scl_run,
  output logic                 o_rx_en,
  output ddr_rx_pkg::rx_mode_e o_rx_mode,
  output logic                 o_crc_clear,
  output logic                 o_frame_done,
  output logic                 o_frame_error
);

  import ddr_rx_pkg::*;

  localparam int WCNT_W = $clog2(MAX_WORDS + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_END
  } ctrl_state_e;

  ctrl_state_e       state;
  logic [WCNT_W-1:0] word_cnt;
  logic              second_byte;
  logic              overflow;
  logic              stop;

  // data preamble after the last allowed word
  assign overflow = (o_rx_mode == PREAMBLE) && i_pre_bit &&
                    (word_cnt == WCNT_W'(MAX_WORDS));
  assign stop     = (state == ST_RUN) && i_mode_done &&
                    (i_error || overflow || (o_rx_mode == CHECK_CRC_VALUE));

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      state         <= ST_IDLE;
      word_cnt      <= '0;
      second_byte   <= 1'b0;
      o_scl_run     <= 1'b0;
      o_rx_en       <= 1'b0;
      o_rx_mode     <= IDLE_MODE;
      o_crc_clear   <= 1'b0;
      o_frame_done  <= 1'b0;
      o_frame_error <= 1'b0;
    end
    else
    begin
      o_crc_clear  <= 1'b0;
      o_frame_done <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          // start is only taken between messages
          if (i_rx_start)
          begin
            state         <= ST_RUN;
            word_cnt      <= '0;
            second_byte   <= 1'b0;
            o_scl_run     <= 1'b1;
            o_rx_en       <= 1'b1;
            o_rx_mode     <= PREAMBLE;
            o_crc_clear   <= 1'b1;
            o_frame_error <= 1'b0;
          end
        end
        ST_RUN:
        begin
          if (stop)
          begin
            // halt SCL now and report next cycle
            state         <= ST_END;
            o_scl_run     <= 1'b0;
            o_rx_en       <= 1'b0;
            o_rx_mode     <= IDLE_MODE;
            o_frame_error <= i_error || overflow;
          end
          else if (i_mode_done)
          begin
            case (o_rx_mode)
              PREAMBLE:
              begin
                if (i_pre_bit)
                begin
                  o_rx_mode   <= DESERIALIZING_BYTE;
                  second_byte <= 1'b0;
                  word_cnt    <= word_cnt + 1'b1;
                end
                else
                begin
                  o_rx_mode <= CRC_PREAMBLE;
                end
              end
              DESERIALIZING_BYTE:
              begin
                // two bytes per data word
                if (second_byte)
                begin
                  o_rx_mode <= CHECK_PAR_VALUE;
                end
                else
                begin
                  second_byte <= 1'b1;
                end
              end
              CHECK_PAR_VALUE: o_rx_mode <= PREAMBLE;
              CRC_PREAMBLE:    o_rx_mode <= CHECK_TOKEN;
              CHECK_TOKEN:     o_rx_mode <= CHECK_CRC_VALUE;
              default:         o_rx_mode <= IDLE_MODE;
            endcase
          end
        end
        ST_END:
        begin
          o_frame_done <= 1'b1;
          state        <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- logic/ddr_rx_top.sv
// receive path top level
// SCL generator, sequencer, deserializer and CRC-5 engine

module ddr_rx_top #(
  parameter int SCL_HALF_CYCLES = 4,
  parameter int MAX_WORDS       = 8
) (
  input  logic                          i_sys_clk,
  input  logic                          i_sys_rst,
  input  logic                          i_rx_start,
  input  logic                          i_sda,
  output logic                          o_scl,
  output logic [ddr_rx_pkg::BYTE_W-1:0] o_rx_data,
  output logic                          o_rx_data_valid,
  output logic                          o_frame_done,
  output logic                          o_frame_error
);

  import ddr_rx_pkg::*;

  logic             scl_run;
  logic             scl_pos_edge;
  logic             scl_neg_edge;
  logic             rx_en;
  rx_mode_e         rx_mode;
  logic             crc_clear;
  logic             mode_done;
  logic             pre_bit;
  logic             rx_error;
  logic [CRC_W-1:0] crc_value;

  // SCL_HALF_CYCLES of 3 or more leaves room for the mode change between bits
  scl_gen #(
    .SCL_HALF_CYCLES(SCL_HALF_CYCLES)
  ) u_scl_gen (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst      (i_sys_rst),
    .i_run          (scl_run),
    .o_scl          (o_scl),
    .o_scl_pos_edge (scl_pos_edge),
    .o_scl_neg_edge (scl_neg_edge)
  );

  ddr_rx_ctrl #(
    .MAX_WORDS(MAX_WORDS)
  ) u_ddr_rx_ctrl (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_rx_start    (i_rx_start),
    .i_mode_done   (mode_done),
    .i_pre_bit     (pre_bit),
    .i_error       (rx_error),
    .o_scl_run     (scl_run),
    .o_rx_en       (rx_en),
    .o_rx_mode     (rx_mode),
    .o_crc_clear   (crc_clear),
    .o_frame_done  (o_frame_done),
    .o_frame_error (o_frame_error)
  );

  // byte strobe doubles as the host data valid
  ddr_rx u_ddr_rx (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst        (i_sys_rst),
    .i_rx_en          (rx_en),
    .i_rx_mode        (rx_mode),
    .i_scl_pos_edge   (scl_pos_edge),
    .i_scl_neg_edge   (scl_neg_edge),
    .i_sda            (i_sda),
    .i_crc_value      (crc_value),
    .o_rx_data        (o_rx_data),
    .o_crc_byte_valid (o_rx_data_valid),
    .o_mode_done      (mode_done),
    .o_pre_bit        (pre_bit),
    .o_error          (rx_error)
  );

  crc5_engine u_crc5_engine (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_clear      (crc_clear),
    .i_byte_valid (o_rx_data_valid),
    .i_byte       (o_rx_data),
    .o_crc        (crc_value)
  );

endmodule

//--- tb/ddr_rx_tb.sv
// testbench for the HDR-DDR receive path
// target model on SDA, byte and edge monitor, directed tests, watchdog

module ddr_rx_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SCL_HALF_CYCLES = 4;
  localparam int MAX_WORDS       = 8;
  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 4;
  localparam int RAND_SEED       = 32'hff22_5409;
  // SDA bits over all messages with each rounded up to an even edge count
  localparam int TOTAL_BITS      = 30 + 68 + 38 + 26 + 22 + 30 + 30;
  localparam int TIMEOUT_CYCLES  = TOTAL_BITS * 2 * SCL_HALF_CYCLES + 400;

  // field corruption kinds for the target model
  localparam int CORRUPT_NONE    = 0;
  localparam int CORRUPT_PARITY  = 1;
  localparam int CORRUPT_CRC_PRE = 2;
  localparam int CORRUPT_TOKEN   = 3;
  localparam int CORRUPT_CRC     = 4;

  logic       i_sys_clk;
  logic       i_sys_rst;
  logic       i_rx_start;
  logic       i_sda;
  logic       o_scl;
  logic [7:0] o_rx_data;
  logic       o_rx_data_valid;
  logic       o_frame_done;
  logic       o_frame_error;

  logic [7:0] tx_data[$];
  logic       tx_bits[$];
  logic [7:0] rx_bytes[$];
  int         done_cnt;
  int         edge_cnt;
  logic       scl_last;

  ddr_rx_top #(
    .SCL_HALF_CYCLES(SCL_HALF_CYCLES),
    .MAX_WORDS      (MAX_WORDS)
  ) u_ddr_rx_top (
    .i_sys_clk       (i_sys_clk),
    .i_sys_rst       (i_sys_rst),
    .i_rx_start      (i_rx_start),
    .i_sda           (i_sda),
    .o_scl           (o_scl),
    .o_rx_data       (o_rx_data),
    .o_rx_data_valid (o_rx_data_valid),
    .o_frame_done    (o_frame_done),
    .o_frame_error   (o_frame_error)
  );

  initial
  begin
    i_sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_sys_clk = ~i_sys_clk;
  end

  // outputs sampled mid-cycle on the falling edge
  initial
  begin
    scl_last = 1'b0;
    done_cnt = 0;
    edge_cnt = 0;
    forever
    begin
      @(negedge i_sys_clk);
      if (o_rx_data_valid)
      begin
        rx_bytes.push_back(o_rx_data);
      end
      if (o_frame_done)
      begin
        done_cnt++;
      end
      if (o_scl != scl_last)
      begin
        edge_cnt++;
      end
      scl_last = o_scl;
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge i_sys_clk);
    $display("Simulation failed");
    $fatal(1, "watchdog expired, a message never finished");
  end

  task automatic check_equal(input string name, input int expected, input int actual);
    if (expected != actual)
    begin
      $display("error %s: expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic load_random(input int n_bytes);
    tx_data.delete();
    repeat (n_bytes) tx_data.push_back(8'($urandom));
  endtask

  // serial message from tx_data with one optional bad field
  task automatic build_message(input int kind, input int bad_word);
    logic [15:0] word;
    logic [4:0]  crc;
    logic [3:0]  token;
    logic        p1;
    logic        p0;
    logic        fb;
    tx_bits.delete();
    crc = 5'h1f;
    for (int w = 0; w < tx_data.size() / 2; w++)
    begin
      word = {tx_data[2*w], tx_data[2*w+1]};
      p1   = 1'b0;
      // starting at 1 gives the inverted even parity
      p0   = 1'b1;
      for (int b = 0; b < 16; b += 2)
      begin
        p1 ^= word[b+1];
        p0 ^= word[b];
      end
      if (kind == CORRUPT_PARITY && w == bad_word)
      begin
        p1 = !p1;
      end
      tx_bits.push_back(1'b1);
      for (int b = 15; b >= 0; b--)
      begin
        tx_bits.push_back(word[b]);
        // x^5 + x^2 + 1 feeds back into bits 0 and 2
        fb  = crc[4] ^ word[b];
        crc = {crc[3], crc[2], crc[1] ^ fb, crc[0], fb};
      end
      tx_bits.push_back(p1);
      tx_bits.push_back(p0);
    end
    // CRC word
    tx_bits.push_back(1'b0);
    tx_bits.push_back(kind != CORRUPT_CRC_PRE);
    token = (kind == CORRUPT_TOKEN) ? 4'ha : 4'hc;
    for (int b = 3; b >= 0; b--)
    begin
      tx_bits.push_back(token[b]);
    end
    if (kind == CORRUPT_CRC)
    begin
      crc ^= 5'b00100;
    end
    for (int b = 4; b >= 0; b--)
    begin
      tx_bits.push_back(crc[b]);
    end
  endtask

  // start pulse and then one SDA bit per SCL change until done
  task automatic run_message();
    int   idx;
    logic prev;
    idx        = 0;
    prev       = o_scl;
    rx_bytes.delete();
    done_cnt   = 0;
    edge_cnt   = 0;
    i_rx_start = 1'b1;
    @(posedge i_sys_clk);
    #1;
    i_rx_start = 1'b0;
    while (!o_frame_done)
    begin
      if (o_scl != prev)
      begin
        prev  = o_scl;
        i_sda = (idx < tx_bits.size()) ? tx_bits[idx] : 1'b0;
        idx++;
      end
      @(posedge i_sys_clk);
      #1;
    end
    // SCL must come to rest
    repeat (4 * SCL_HALF_CYCLES)
    begin
      @(posedge i_sys_clk);
      #1;
    end
  endtask

  task automatic check_message(input string name, input int kind, input int bad_word);
    int n_words;
    int bits_used;
    int exp_bytes;
    n_words = tx_data.size() / 2;
    // an error halts the message right after the bad field
    case (kind)
      CORRUPT_PARITY:  bits_used = 19 * (bad_word + 1);
      CORRUPT_CRC_PRE: bits_used = 19 * n_words + 2;
      CORRUPT_TOKEN:   bits_used = 19 * n_words + 6;
      default:         bits_used = 19 * n_words + 11;
    endcase
    exp_bytes = (kind == CORRUPT_PARITY) ? 2 * (bad_word + 1) : 2 * n_words;
    build_message(kind, bad_word);
    run_message();
    check_equal({name, " done pulses"}, 1, done_cnt);
    check_equal({name, " frame error"}, int'(kind != CORRUPT_NONE), int'(o_frame_error));
    check_equal({name, " byte count"}, exp_bytes, rx_bytes.size());
    for (int i = 0; i < exp_bytes; i++)
    begin
      check_equal($sformatf("%s byte %0d", name, i), tx_data[i], rx_bytes[i]);
    end
    // high SCL finishes its half period so the count rounds up to even
    check_equal({name, " scl edges"}, bits_used + bits_used % 2, edge_cnt);
    check_equal({name, " scl idle"}, 0, int'(o_scl));
  endtask

  task automatic test_reset();
    check_equal("reset scl", 0, int'(o_scl));
    check_equal("reset data valid", 0, int'(o_rx_data_valid));
    check_equal("reset frame done", 0, int'(o_frame_done));
    check_equal("reset frame error", 0, int'(o_frame_error));
    rx_bytes.delete();
    edge_cnt = 0;
    repeat (8 * SCL_HALF_CYCLES) @(posedge i_sys_clk);
    #1;
    check_equal("reset idle bytes", 0, rx_bytes.size());
    check_equal("reset idle edges", 0, edge_cnt);
  endtask

  task automatic test_single_word();
    tx_data.delete();
    tx_data.push_back(8'ha5);
    tx_data.push_back(8'h3c);
    check_message("single word", CORRUPT_NONE, 0);
  endtask

  task automatic test_random_words();
    load_random(6);
    check_message("three words", CORRUPT_NONE, 0);
  endtask

  task automatic test_parity_error();
    load_random(6);
    check_message("parity error", CORRUPT_PARITY, 1);
  endtask

  task automatic test_crc_word_errors();
    load_random(2);
    check_message("bad token", CORRUPT_TOKEN, 0);
    load_random(2);
    check_message("bad crc preamble", CORRUPT_CRC_PRE, 0);
  endtask

  task automatic test_crc_error_recovery();
    load_random(2);
    check_message("bad crc", CORRUPT_CRC, 0);
    load_random(2);
    check_message("after bad crc", CORRUPT_NONE, 0);
  endtask

  initial
  begin
    i_sys_rst  = 1'b0;
    i_rx_start = 1'b0;
    i_sda      = 1'b0;
    void'($urandom(RAND_SEED));
    repeat (RESET_CYCLES) @(posedge i_sys_clk);
    #1;
    i_sys_rst = 1'b1;
    test_reset();
    test_single_word();
    test_random_words();
    test_parity_error();
    test_crc_word_errors();
    test_crc_error_recovery();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- filelist.f
logic/ddr_rx_pkg.sv
logic/scl_gen.sv
logic/crc5_engine.sv
logic/ddr_rx.sv
logic/ddr_rx_ctrl.sv
logic/ddr_rx_top.sv
tb/ddr_rx_tb.sv

//--- Makefile
SIM        = verilator
TOP        = ddr_rx_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
